/* stim_mips.txt */
# instr    mem_data  wb_valid wb_reg wb_data   next_pc   name
# All fields hex except name. Core boots at bfc00000.
3c011234 00000000 1 01 12340000 bfc00004 LUI
34215678 00000000 1 01 12345678 bfc00008 ORI
34030ff0 00000000 1 03 00000ff0 bfc0000c ORI
00231021 00000000 1 02 12346668 bfc00010 ADDU
00612023 00000000 1 04 edcbb978 bfc00014 SUBU
00232824 00000000 1 05 00000670 bfc00018 AND
00833025 00000000 1 06 edcbbff8 bfc0001c OR
0081102a 00000000 1 02 00000001 bfc00020 SLT
0024382a 00000000 1 07 00000000 bfc00024 SLT
2462fff0 00000000 1 02 00000fe0 bfc00028 ADDIU
00230021 00000000 0 00 00000000 bfc0002c ADDU_R0
00013821 00000000 1 07 12345678 bfc00030 ADDU
8c080000 a1b2c3d4 1 08 a1b2c3d4 bfc00034 LW
00014821 00000000 1 09 12345678 bfc00038 ADDU
88090003 aabbccdd 1 09 dd345678 bfc0003c LWL_B3
88090002 11223344 1 09 33445678 bfc00040 LWL_B2
88090001 55667788 1 09 66778878 bfc00044 LWL_B1
88090000 99aabbcc 1 09 99aabbcc bfc00048 LWL_B0
00015021 00000000 1 0a 12345678 bfc0004c ADDU
980a0000 aabbccdd 1 0a 123456aa bfc00050 LWR_B0
980a0001 11223344 1 0a 12341122 bfc00054 LWR_B1
980a0002 55667788 1 0a 12556677 bfc00058 LWR_B2
980a0003 99aabbcc 1 0a 99aabbcc bfc0005c LWR_B3
0bf00040 00000000 0 00 00000000 bfc00100 J
0ff00080 00000000 1 1f bfc00108 bfc00200 JAL
03e00008 00000000 0 00 00000000 bfc00108 JR
3c05bfc0 00000000 1 05 bfc00000 bfc0010c LUI
34a50300 00000000 1 05 bfc00300 bfc00110 ORI
00a03009 00000000 1 06 bfc00118 bfc00300 JALR
00c01021 00000000 1 02 bfc00118 bfc00304 ADDU
03e01021 00000000 1 02 bfc00108 bfc00308 ADDU

/* sources.f */
mips_pkg.sv
control_fsm.sv
pc_counter.sv
alu.sv
regfile.sv
mips_wb_core.sv
wb_checker.sv
tb_mips_wb_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_mips_wb_core \
	-f sources.f -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat build.log
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0

/* tb_mips_wb_core.sv */
`timescale 1ns/100ps

module tb_mips_wb_core;
	import mips_pkg::*;

	localparam word_t RESET_PC = 32'hBFC00000;

	logic        clk;
	logic        reset;
	logic        start;
	word_t       instr;
	word_t       mem_data;
	logic        ready;
	logic        done;
	wb_t         wb;
	word_t       register_v0;
	word_t       pc;

	logic        exp_valid;
	reg_addr_t   exp_addr;
	word_t       exp_data;
	word_t       exp_pc;
	int          test_line;
	logic [63:0] test_name;
	logic        end_run;
	int          instr_count;
	int          error_count;
	int          setup_errors = 0;
	int          seed;
	int          cycles = 0;
	int          timeout_limit = 0;

	word_t       q_instr[$];
	word_t       q_mem[$];
	logic        q_valid[$];
	reg_addr_t   q_reg[$];
	word_t       q_data[$];
	word_t       q_pc[$];
	int          q_line[$];
	logic [63:0] q_name[$];

	mips_wb_core #(.RESET_PC(RESET_PC)) mips_wb_core_i (
		.clk(clk), .reset(reset), .start(start), .instr(instr), .mem_data(mem_data),
		.ready(ready), .done(done), .wb(wb), .register_v0(register_v0), .pc(pc)
	);

	wb_checker #(.RESET_PC(RESET_PC)) wb_checker_i (
		.clk(clk), .reset(reset), .start(start), .ready(ready), .done(done), .wb(wb),
		.register_v0(register_v0), .pc(pc), .exp_valid(exp_valid), .exp_addr(exp_addr),
		.exp_data(exp_data), .exp_pc(exp_pc), .test_line(test_line), .test_name(test_name),
		.end_run(end_run), .instr_count(instr_count), .error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ======================================================================
	// Stimulus file and per-instruction sequence
	// ======================================================================
	task automatic load_stimulus();
		int               fd;
		int               line_no;
		int               got;
		logic [8*128-1:0] line_buf;
		word_t            t_instr;
		word_t            t_mem;
		word_t            t_data;
		word_t            t_pc;
		logic             t_valid;
		reg_addr_t        t_reg;
		logic [63:0]      t_name;
		line_no = 0;
		fd = $fopen("stim_mips.txt", "r");
		if (fd == 0) begin
			$display("Cannot open stim_mips.txt for reading");
			setup_errors++;
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				t_name   = '0;
				got = $fgets(line_buf, fd);
				line_no++;
				if ((got > 0) && ($sscanf(line_buf, "%h %h %h %h %h %h %s", t_instr, t_mem,
						t_valid, t_reg, t_data, t_pc, t_name) == 7)) begin
					q_instr.push_back(t_instr);
					q_mem.push_back(t_mem);
					q_valid.push_back(t_valid);
					q_reg.push_back(t_reg);
					q_data.push_back(t_data);
					q_pc.push_back(t_pc);
					q_line.push_back(line_no);
					q_name.push_back(t_name);
				end
			end
			$fclose(fd);
		end
		if (q_instr.size() == 0) begin
			$display("No instructions found in stim_mips.txt");
			setup_errors++;
		end
	endtask

	task automatic run_instr(input int idx);
		while (!ready) @(negedge clk);
		instr     <= q_instr[idx];
		mem_data  <= q_mem[idx];
		exp_valid <= q_valid[idx];
		exp_addr  <= q_reg[idx];
		exp_data  <= q_data[idx];
		exp_pc    <= q_pc[idx];
		test_line <= q_line[idx];
		test_name <= q_name[idx];
		start     <= 1'b1;
		@(negedge clk);
		start <= 1'b0;
		if ((idx % 3) == 1) begin
			@(negedge clk);
			start <= 1'b1; // Core is busy here.
			@(negedge clk);
			start <= 1'b0;
		end
		while (!done) @(negedge clk);
		@(negedge clk); // Writeback visible.
	endtask

	always @(posedge clk) begin
		cycles++;
		if ((timeout_limit > 0) && (cycles >= timeout_limit)) begin
			$display("Run timed out after %0d cycles without finishing", cycles);
			$display("Errors: %0d, setup errors: %0d", error_count, setup_errors);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int idle;
		reset       = 1'b1;
		start       = 1'b0;
		instr       = '0;
		mem_data    = '0;
		exp_valid   = 1'b0;
		exp_addr    = '0;
		exp_data    = '0;
		exp_pc      = '0;
		test_line   = 0;
		test_name   = '0;
		end_run     = 1'b0;
		instr_count = 0;
		seed        = 96;
		load_stimulus();
		instr_count   = q_instr.size();
		timeout_limit = q_instr.size() * 10 + 20;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
		for (int i = 0; i < q_instr.size(); i++) begin
			idle = $unsigned($random(seed)) % 4;
			repeat (idle) @(negedge clk);
			run_instr(i);
		end
		end_run <= 1'b1;
		@(negedge clk);
		end_run <= 1'b0;
		@(posedge clk);
		$display("Errors: %0d, setup errors: %0d", error_count, setup_errors);
		if ((error_count == 0) && (setup_errors == 0)) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* wb_checker.sv */
`timescale 1ns/100ps

module wb_checker #(
	parameter mips_pkg::word_t RESET_PC = mips_pkg::DEFAULT_RESET_PC
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  logic                 ready,
	input  logic                 done,
	input  mips_pkg::wb_t        wb,
	input  mips_pkg::word_t      register_v0,
	input  mips_pkg::word_t      pc,
	input  logic                 exp_valid,
	input  mips_pkg::reg_addr_t  exp_addr,
	input  mips_pkg::word_t      exp_data,
	input  mips_pkg::word_t      exp_pc,
	input  int                   test_line,
	input  logic [63:0]          test_name,
	input  logic                 end_run,
	input  int                   instr_count,
	output int                   error_count
);
	import mips_pkg::*;

	localparam int DONE_LATENCY = 4; // Counting the cycle start is presented in.

	int          errors = 0;
	int          done_count = 0;
	int          latency = 0;
	logic        ready_prev = 1'b0;
	logic        busy = 1'b0;
	logic        pending = 1'b0;
	logic        hold_valid;
	reg_addr_t   hold_addr;
	word_t       hold_data;
	word_t       hold_pc;
	int          hold_line;
	logic [63:0] hold_name;

	assign error_count = errors;

	task automatic check_word(input int line, input logic [63:0] name, input string what,
			input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Error: line %0d %0s %0s expected %h actual %h", line, name, what,
				expected, actual);
			errors++;
		end
	endtask

	task automatic compare_writeback();
		check_word(hold_line, hold_name, "wb.valid", {31'b0, hold_valid}, {31'b0, wb.valid});
		if (hold_valid) begin
			check_word(hold_line, hold_name, "wb.addr", {27'b0, hold_addr}, {27'b0, wb.addr});
			check_word(hold_line, hold_name, "wb.data", hold_data, wb.data);
			if (hold_addr == REG_V0) begin
				check_word(hold_line, hold_name, "register_v0", hold_data, register_v0);
			end
		end
		check_word(hold_line, hold_name, "pc", hold_pc, pc);
	endtask

	// ======================================================================
	// Sampling on the falling edge
	// ======================================================================
	always @(negedge clk) begin
		if (reset) begin
			check_word(0, "ON_RESET", "ready", 32'd1, {31'b0, ready});
			check_word(0, "ON_RESET", "wb.valid", 32'd0, {31'b0, wb.valid});
			check_word(0, "ON_RESET", "pc", RESET_PC, pc);
			check_word(0, "ON_RESET", "register_v0", 32'd0, register_v0);
			busy    = 1'b0;
			pending = 1'b0;
		end else begin
			if (pending) begin
				compare_writeback();
				pending = 1'b0;
			end
			if (busy) begin
				latency++;
			end
			if (start && ready_prev && !busy) begin
				busy    = 1'b1;
				latency = 2; // Start cycle plus this one.
			end
			if (done) begin
				hold_valid = exp_valid;
				hold_addr  = exp_addr;
				hold_data  = exp_data;
				hold_pc    = exp_pc;
				hold_line  = test_line;
				hold_name  = test_name;
				if (!busy) begin
					$display("Done pulse seen with no accepted start at line %0d", test_line);
					errors++;
				end else begin
					check_word(hold_line, hold_name, "latency", word_t'(DONE_LATENCY),
						word_t'(latency));
				end
				done_count++;
				busy    = 1'b0;
				pending = 1'b1; // Outputs settle on the next edge.
			end
			if (end_run && (done_count != instr_count)) begin
				$display("Saw %0d done pulses for %0d instructions", done_count, instr_count);
				errors++;
			end
		end
		ready_prev = ready;
	end

endmodule

/* mips_wb_core.sv */
`timescale 1ns/100ps

module mips_wb_core #(
	parameter mips_pkg::word_t RESET_PC = mips_pkg::DEFAULT_RESET_PC
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            start,
	input  mips_pkg::word_t instr,
	input  mips_pkg::word_t mem_data,
	output logic            ready,
	output logic            done,
	output mips_pkg::wb_t   wb,
	output mips_pkg::word_t register_v0,
	output mips_pkg::word_t pc
);
	import mips_pkg::*;

	word_t    instr_q;
	word_t    mem_q;
	decoded_t dec;
	logic     read_en;
	logic     exec_en;
	logic     write_en;
	word_t    rs_data;
	word_t    rt_data;
	word_t    alu_result;
	word_t    link_addr;

	// Inputs track while idle, so the accepting edge holds them.
	always_ff @(posedge clk) begin
		if (ready) begin
			instr_q <= instr;
			mem_q   <= mem_data;
		end
	end

	always_comb begin
		dec.opcode = instr_q[31:26];
		dec.rs     = instr_q[25:21];
		dec.rt     = instr_q[20:16];
		dec.rd     = instr_q[15:11];
		dec.funct  = instr_q[5:0];
		dec.imm    = instr_q[15:0];
		dec.target = instr_q[25:0];
	end

	control_fsm control_fsm_i (
		.clk(clk), .reset(reset), .start(start), .ready(ready),
		.read_en(read_en), .exec_en(exec_en), .write_en(write_en), .done(done)
	);

	pc_counter #(.RESET_PC(RESET_PC)) pc_counter_i (
		.clk(clk), .reset(reset), .write_en(write_en), .dec(dec),
		.rs_data(rs_data), .pc(pc), .link_addr(link_addr)
	);

	alu alu_i (
		.clk(clk), .reset(reset), .exec_en(exec_en), .dec(dec),
		.rs_data(rs_data), .rt_data(rt_data), .result(alu_result)
	);

	regfile regfile_i (
		.clk(clk), .reset(reset), .read_en(read_en), .write_en(write_en),
		.dec(dec), .alu_result(alu_result), .mem_data(mem_q), .link_addr(link_addr),
		.rs_data(rs_data), .rt_data(rt_data), .wb(wb), .register_v0(register_v0)
	);

endmodule

/* regfile.sv */
`timescale 1ns/100ps

module regfile (
	input  logic               clk,
	input  logic               reset,
	input  logic               read_en,
	input  logic               write_en,
	input  mips_pkg::decoded_t dec,
	input  mips_pkg::word_t    alu_result,
	input  mips_pkg::word_t    mem_data,
	input  mips_pkg::word_t    link_addr,
	output mips_pkg::word_t    rs_data,
	output mips_pkg::word_t    rt_data,
	output mips_pkg::wb_t      wb,
	output mips_pkg::word_t    register_v0
);
	import mips_pkg::*;

	word_t     regs [32];
	reg_addr_t dest;
	logic      writes;
	logic      is_link;
	logic [1:0] byte_off;
	word_t     old_val;
	word_t     merged;
	word_t     wr_data;

	// ======================================================================
	// Destination select
	// ======================================================================
	always_comb begin
		writes = 1'b1;
		dest   = dec.rt;
		case (dec.opcode)
			OP_RTYPE: begin
				dest = dec.rd; // JALR links through rd as well.
				if (dec.funct == FN_JR) begin
					writes = 1'b0;
				end
			end
			OP_JAL: dest = REG_RA;
			OP_J:   writes = 1'b0;
			default: dest = dec.rt;
		endcase
	end

	assign is_link  = (dec.opcode == OP_JAL) ||
		((dec.opcode == OP_RTYPE) && (dec.funct == FN_JALR));
	assign byte_off = alu_result[1:0]; // From the effective address.
	assign old_val  = regs[dest];

	// ======================================================================
	// Partial word merge
	// ======================================================================
	always_comb begin
		if (dec.opcode == OP_LWL) begin
			case (byte_off)
				2'd0: merged = mem_data;
				2'd1: merged = {mem_data[23:0], old_val[7:0]};
				2'd2: merged = {mem_data[15:0], old_val[15:0]};
				default: merged = {mem_data[7:0], old_val[23:0]};
			endcase
		end else begin
			case (byte_off)
				2'd0: merged = {old_val[31:8], mem_data[31:24]};
				2'd1: merged = {old_val[31:16], mem_data[31:16]};
				2'd2: merged = {old_val[31:24], mem_data[31:8]};
				default: merged = mem_data;
			endcase
		end
	end

	always_comb begin
		if (is_link) begin
			wr_data = link_addr;
		end else if (dec.opcode == OP_LW) begin
			wr_data = mem_data;
		end else if ((dec.opcode == OP_LWL) || (dec.opcode == OP_LWR)) begin
			wr_data = merged;
		end else begin
			wr_data = alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
			rs_data <= '0;
			rt_data <= '0;
			wb      <= '0;
		end else begin
			if (read_en) begin
				rs_data <= regs[dec.rs];
				rt_data <= regs[dec.rt];
			end
			if (write_en) begin
				if (writes && (dest != '0)) begin
					regs[dest] <= wr_data;
				end
				wb.valid <= writes && (dest != '0); // $zero never reported.
				wb.addr  <= dest;
				wb.data  <= wr_data;
			end
		end
	end

	assign register_v0 = regs[REG_V0];

endmodule

/* alu.sv */
`timescale 1ns/100ps

module alu (
	input  logic               clk,
	input  logic               reset,
	input  logic               exec_en,
	input  mips_pkg::decoded_t dec,
	input  mips_pkg::word_t    rs_data,
	input  mips_pkg::word_t    rt_data,
	output mips_pkg::word_t    result
);
	import mips_pkg::*;

	word_t imm_sext;
	word_t imm_zext;
	word_t op_result;

	assign imm_sext = {{16{dec.imm[15]}}, dec.imm};
	assign imm_zext = {16'h0000, dec.imm};

	always_comb begin
		op_result = '0;
		case (dec.opcode)
			OP_RTYPE: begin
				case (dec.funct)
					FN_ADDU: op_result = rs_data + rt_data;
					FN_SUBU: op_result = rs_data - rt_data;
					FN_AND:  op_result = rs_data & rt_data;
					FN_OR:   op_result = rs_data | rt_data;
					FN_SLT:  op_result = {31'b0, $signed(rs_data) < $signed(rt_data)};
					default: op_result = '0;
				endcase
			end
			OP_ADDIU: op_result = rs_data + imm_sext;
			OP_ORI:   op_result = rs_data | imm_zext;
			OP_LUI:   op_result = {dec.imm, 16'h0000};
			OP_LW, OP_LWL, OP_LWR: op_result = rs_data + imm_sext; // Effective address.
			default:  op_result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else if (exec_en) begin
			result <= op_result;
		end
	end

endmodule

/* pc_counter.sv */
`timescale 1ns/100ps

module pc_counter #(
	parameter mips_pkg::word_t RESET_PC = mips_pkg::DEFAULT_RESET_PC
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               write_en,
	input  mips_pkg::decoded_t dec,
	input  mips_pkg::word_t    rs_data,
	output mips_pkg::word_t    pc,
	output mips_pkg::word_t    link_addr
);
	import mips_pkg::*;

	word_t pc_plus4;
	word_t pc_next;
	logic  jump_reg;

	assign pc_plus4  = pc + 32'd4;
	assign link_addr = pc + 32'd8; // Skips the delay slot.
	assign jump_reg  = (dec.opcode == OP_RTYPE) &&
		((dec.funct == FN_JR) || (dec.funct == FN_JALR));

	always_comb begin
		if ((dec.opcode == OP_J) || (dec.opcode == OP_JAL)) begin
			pc_next = {pc_plus4[31:28], dec.target, 2'b00}; // Same 256MB region.
		end else if (jump_reg) begin
			pc_next = rs_data;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_PC;
		end else if (write_en) begin
			pc <= pc_next;
		end
	end

endmodule

/* control_fsm.sv */
`timescale 1ns/100ps

module control_fsm (
	input  logic clk,
	input  logic reset,
	input  logic start,
	output logic ready,
	output logic read_en,
	output logic exec_en,
	output logic write_en,
	output logic done
);
	import mips_pkg::*;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// One cycle per state once started.
	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (start) begin
					state_next = S_READ;
				end
			end
			S_READ: begin
				state_next = S_EXEC;
			end
			S_EXEC: begin
				state_next = S_WRITE;
			end
			S_WRITE: begin
				state_next = S_IDLE;
			end
			default: begin
				state_next = S_IDLE;
			end
		endcase
	end

	assign ready    = (state == S_IDLE); // Start only counts here.
	assign read_en  = (state == S_READ);
	assign exec_en  = (state == S_EXEC);
	assign write_en = (state == S_WRITE);
	assign done     = (state == S_WRITE); // Writeback lands at the end of this cycle.

endmodule

/* mips_pkg.sv */
package mips_pkg;

	// ======================================================================
	// Widths
	// ======================================================================
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [15:0] imm_t;
	typedef logic [25:0] target_t;

	localparam word_t DEFAULT_RESET_PC = 32'hBFC00000; // Boot ROM vector.

	// ======================================================================
	// Opcodes and functs
	// ======================================================================
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J     = 6'h02;
	localparam opcode_t OP_JAL   = 6'h03;
	localparam opcode_t OP_ADDIU = 6'h09;
	localparam opcode_t OP_ORI   = 6'h0D;
	localparam opcode_t OP_LUI   = 6'h0F;
	localparam opcode_t OP_LWL   = 6'h22;
	localparam opcode_t OP_LW    = 6'h23;
	localparam opcode_t OP_LWR   = 6'h26;

	localparam funct_t FN_JR   = 6'h08;
	localparam funct_t FN_JALR = 6'h09;
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_SLT  = 6'h2A;

	localparam reg_addr_t REG_V0 = 5'd2;
	localparam reg_addr_t REG_RA = 5'd31; // Link register.

	// ======================================================================
	// Structs and states
	// ======================================================================
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		funct_t    funct;
		imm_t      imm;
		target_t   target;
	} decoded_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

	typedef enum logic [1:0] {S_IDLE, S_READ, S_EXEC, S_WRITE} state_t;

endpackage
